// File: hw/dmem_pkg.sv
package dmem_pkg;

	// store size codes, 3 bits wide
	// anything other than byte or halfword stores a full word
	localparam logic [2:0] SEL_SB = 3'd0;
	localparam logic [2:0] SEL_SH = 3'd1;

	// load size codes
	// zero or sign extension for bytes and halfwords
	// any other code returns the full word unchanged
	localparam logic [2:0] SEL_LBU = 3'd3;
	localparam logic [2:0] SEL_LB  = 3'd4;
	localparam logic [2:0] SEL_LHU = 3'd5;
	localparam logic [2:0] SEL_LH  = 3'd6;

	// uncached segment base
	// subtracted from every core address before indexing
	localparam logic [31:0] KSEG_BASE = 32'ha000_0000;

	// bank depth in 32-bit words, 8 KiB total
	localparam int DMEM_WORDS = 2048;

	// word index width, log2 of the depth
	localparam int WORD_IDX_W = 11;

	// one memory word with two lane views
	// b[0] is the byte at offset 0, b[3] the byte at offset 3
	// h[0] is the low halfword, picked when address bit 1 is clear
	// store side writes lanes through it
	// load side reads lanes back through it
	typedef union packed {
		logic [3:0][7:0]  b;
		logic [1:0][15:0] h;
	} mem_word_u;

	// little-endian lane order throughout
	// lane i of wen covers b[i]
	// an aligned halfword uses lanes 1:0 or 3:2
	// a full word uses all four lanes
	// no other strobe pattern is legal

	// end of shared definitions

endpackage

// File: hw/sram_port_if.sv
`timescale 1ns/100ps

interface sram_port_if;

	// lane write strobes, one per byte
	logic [3:0] wen;
	// word index into the bank
	logic [dmem_pkg::WORD_IDX_W-1:0] addr;
	// replicated store data
	dmem_pkg::mem_word_u wdata;
	// registered read word, one cycle behind addr
	dmem_pkg::mem_word_u rdata;

	// store formatter side
	modport bridge (output wen, output addr, output wdata, input rdata);

	// the SRAM bank side
	modport bank (input wen, input addr, input wdata, output rdata);

	// load extractor only looks at the returned word
	modport sink (input rdata);

endinterface

// File: hw/store_lane_format.sv
`timescale 1ns/100ps

module store_lane_format (
	input  logic        dm_wr,
	input  logic [2:0]  dm_sel_st,
	input  logic [31:0] st_addr,
	input  logic [31:0] din,
	sram_port_if.bridge port
);

	// physical byte address after removing the segment base
	logic [31:0] phys_addr;
	// byte offset inside the word
	logic [1:0] byte_off;
	// replicated write word
	dmem_pkg::mem_word_u wr_word;

	assign phys_addr = st_addr - dmem_pkg::KSEG_BASE;
	// base has zero low bits, offset survives the subtraction
	assign byte_off = phys_addr[1:0];

	// word index, byte offset dropped
	assign port.addr = phys_addr[dmem_pkg::WORD_IDX_W+1:2];

	// lane strobes
	always_comb begin
		if (!dm_wr) begin
			// no write this cycle
			port.wen = 4'b0000;
		end else begin
			case (dm_sel_st)
				dmem_pkg::SEL_SB: port.wen = 4'b0001 << byte_off;
				// halfword picks low or high lane pair by bit 1
				dmem_pkg::SEL_SH: port.wen = byte_off[1] ? 4'b1100 : 4'b0011;
				default:          port.wen = 4'b1111;
			endcase
		end
	end

	// data replicated across lanes
	// the strobes decide which copy lands
	always_comb begin
		case (dm_sel_st)
			dmem_pkg::SEL_SB: wr_word.b = {4{din[7:0]}};
			dmem_pkg::SEL_SH: wr_word.h = {2{din[15:0]}};
			default:          wr_word   = din;
		endcase
	end

	assign port.wdata = wr_word;

	// misaligned stores are only flagged, never trapped
	// checked once inputs settle, stores only
	always_comb begin
		if (dm_wr && dm_sel_st == dmem_pkg::SEL_SH) begin
			a_sh_aligned: assert final (byte_off[0] == 1'b0);
		end
		if (dm_wr && dm_sel_st != dmem_pkg::SEL_SB && dm_sel_st != dmem_pkg::SEL_SH) begin
			a_sw_aligned: assert final (byte_off == 2'b00);
		end
		// index would wrap silently inside the bank
		if (dm_wr) begin
			a_in_range: assert final (phys_addr < 32'(dmem_pkg::DMEM_WORDS * 4));
		end
	end

endmodule

// File: hw/load_lane_extract.sv
`timescale 1ns/100ps

module load_lane_extract (
	input  logic        clk,
	input  logic [2:0]  dm_sel_ld,
	input  logic [31:0] ld_addr,
	sram_port_if.sink   port,
	output logic [31:0] dout
);

	// addressed byte, lane from bits 1:0
	logic [7:0] ld_byte;
	// addressed halfword, lane from bit 1
	logic [15:0] ld_half;
	// full word view of the returned data
	logic [31:0] ld_word;

	// ld_addr still carries the segment base
	// only the low two bits matter here
	assign ld_byte = port.rdata.b[ld_addr[1:0]];
	assign ld_half = port.rdata.h[ld_addr[1]];
	assign ld_word = port.rdata;

	// extension by load code
	always_comb begin
		case (dm_sel_ld)
			// lbu
			dmem_pkg::SEL_LBU: begin
				dout = {24'h00_0000, ld_byte};
			end
			// lb, top bit copied up
			dmem_pkg::SEL_LB: begin
				dout = {{24{ld_byte[7]}}, ld_byte};
			end
			// lhu
			dmem_pkg::SEL_LHU: begin
				dout = {16'h0000, ld_half};
			end
			// lh
			dmem_pkg::SEL_LH: begin
				dout = {{16{ld_half[15]}}, ld_half};
			end
			// lw and any unused code
			default: begin
				dout = ld_word;
			end
		endcase
	end

	// halfword loads must sit on an even byte
	// otherwise the lane pick would drop a byte
	a_lh_aligned: assert property (
		@(posedge clk)
		(dm_sel_ld == dmem_pkg::SEL_LHU || dm_sel_ld == dmem_pkg::SEL_LH) |-> !ld_addr[0]
	);

endmodule

// File: hw/data_sram_bank.sv
`timescale 1ns/100ps

module data_sram_bank (
	input  logic     clk,
	input  logic     arst_n,
	sram_port_if.bank port
);

	// storage, contents undefined after reset
	dmem_pkg::mem_word_u mem [dmem_pkg::DMEM_WORDS];

	// per-lane write
	// untouched lanes keep their old bytes
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (port.wen[i]) begin
				mem[port.addr].b[i] <= port.wdata.b[i];
			end
		end
	end

	// registered read
	// samples the array before this edge's write lands
	// so a same-cycle read returns the old word
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			port.rdata <= '0;
		end else begin
			port.rdata <= mem[port.addr];
		end
	end

	// legal strobe patterns
	// idle, single byte, aligned halfword or full word
	a_wen_legal: assert property (
		@(posedge clk) disable iff (!arst_n)
		port.wen inside {
			4'b0000,
			4'b0001, 4'b0010, 4'b0100, 4'b1000,
			4'b0011, 4'b1100,
			4'b1111
		}
	);

endmodule

// File: hw/dmem_bridge.sv
`timescale 1ns/100ps

module dmem_bridge (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        dm_wr,
	input  logic [2:0]  dm_sel_st,
	input  logic [2:0]  dm_sel_ld,
	input  logic [31:0] st_addr,
	input  logic [31:0] ld_addr,
	input  logic [31:0] din,
	output logic [31:0] dout
);

	// one link joins formatter, extractor and bank
	sram_port_if sram_port ();

	// memory-stage side
	// st_addr also drives the read index every cycle
	store_lane_format u_store_fmt (
		.dm_wr     (dm_wr),
		.dm_sel_st (dm_sel_st),
		.st_addr   (st_addr),
		.din       (din),
		.port      (sram_port)
	);

	// write-back-stage side
	// sees the word read one edge earlier
	load_lane_extract u_load_ext (
		.clk       (clk),
		.dm_sel_ld (dm_sel_ld),
		.ld_addr   (ld_addr),
		.port      (sram_port),
		.dout      (dout)
	);

	// always enabled
	// lane strobes are the only write control
	data_sram_bank u_bank (
		.clk    (clk),
		.arst_n (arst_n),
		.port   (sram_port)
	);

endmodule

// File: verification/tb_dmem_bridge.sv
`timescale 1ns/100ps

module tb_dmem_bridge;

	// DUT pins
	logic        clk;
	logic        arst_n;
	logic        dm_wr;
	logic [2:0]  dm_sel_st;
	logic [2:0]  dm_sel_ld;
	logic [31:0] st_addr;
	logic [31:0] ld_addr;
	logic [31:0] din;
	logic [31:0] dout;

	// parsed accesses, one entry per data line
	logic [7:0]  op_q[$];
	logic [2:0]  sel_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] val_q[$];

	// read index parked here at reset release
	// top word of the bank, untouched by the cases
	localparam logic [31:0] PARK_ADDR = dmem_pkg::KSEG_BASE + 32'h0000_1ffc;

	dmem_bridge DUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.dm_wr     (dm_wr),
		.dm_sel_st (dm_sel_st),
		.dm_sel_ld (dm_sel_ld),
		.st_addr   (st_addr),
		.ld_addr   (ld_addr),
		.din       (din),
		.dout      (dout)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// compare one load result against the expected word
	task automatic check_load(input logic [31:0] expected);
		if (dout !== expected) begin
			$display("ERROR %0t ns: load from %h returned %h, expected %h",
				$time, ld_addr, dout, expected);
			$display("TB FAILED");
			$fatal(1, "load result mismatch");
		end
	endtask

	// fill the queues from the cases file
	task automatic parse_cases(output bit ok);
		integer fd;
		integer cnt;
		integer ch;
		bit done;
		logic [7:0] op;
		logic [2:0] sel;
		logic [31:0] addr;
		logic [31:0] val;
		ok = 1'b1;
		done = 1'b0;
		fd = $fopen("verification/dmem_bridge_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/dmem_bridge_cases.txt");
			ok = 1'b0;
			done = 1'b1;
		end
		while (!done) begin
			// leading space skips blanks and newlines
			cnt = $fscanf(fd, " %c", op);
			if (cnt != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				// comment, drop the rest of the line
				ch = $fgetc(fd);
				while (ch != "\n" && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else begin
				cnt = $fscanf(fd, "%h %h %h", sel, addr, val);
				if (cnt != 3 || !(op == "S" || op == "N" || op == "L" || op == "U")) begin
					$display("cases file has a malformed line after %0d accesses",
						op_q.size());
					ok = 1'b0;
					done = 1'b1;
				end else begin
					op_q.push_back(op);
					sel_q.push_back(sel);
					addr_q.push_back(addr);
					val_q.push_back(val);
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	// one store cycle, wr low leaves the bank alone
	task automatic drive_store(
		input logic [2:0]  sel,
		input logic [31:0] addr,
		input logic [31:0] data,
		input logic        wr
	);
		@(posedge clk);
		dm_wr     <= wr;
		dm_sel_st <= sel;
		st_addr   <= addr;
		din       <= data;
	endtask

	// address out on the store side, then the same address on the load side
	task automatic fetch_load(
		input logic [2:0]  sel,
		input logic [31:0] addr,
		input logic [31:0] expected,
		input bit          checked
	);
		@(posedge clk);
		dm_wr   <= 1'b0;
		st_addr <= addr;
		// rdata registered here
		@(posedge clk);
		ld_addr   <= addr;
		dm_sel_ld <= sel;
		// dout settled mid cycle
		@(negedge clk);
		if (checked) begin
			check_load(expected);
		end
	endtask

	initial begin
		bit cases_ok;
		integer timeout_ns;
		integer i;
		// idle bus, word codes on both sides
		arst_n    = 1'b0;
		dm_wr     = 1'b0;
		dm_sel_st = 3'd2;
		dm_sel_ld = 3'd2;
		st_addr   = dmem_pkg::KSEG_BASE;
		ld_addr   = dmem_pkg::KSEG_BASE;
		din       = 32'h0000_0000;
		parse_cases(cases_ok);
		if (!cases_ok) begin
			$display("TB FAILED");
			$fatal(1, "cases file unusable");
		end else begin
			// worst case three cycles per access plus reset margin
			timeout_ns = op_q.size() * 3 * 4 + 200;
			fork
				begin
					#(timeout_ns);
					$display("timeout: accesses did not finish within %0d ns", timeout_ns);
					$display("TB FAILED");
					$fatal(1, "watchdog expired");
				end
			join_none
			repeat (8) @(posedge clk);
			arst_n  <= 1'b1;
			// move the index so the reset zero is not compared to old memory
			st_addr <= PARK_ADDR;
			// rdata still cleared before the first live edge
			@(negedge clk);
			check_load(32'h0000_0000);
			for (i = 0; i < op_q.size(); i++) begin
				case (op_q[i])
					"S":     drive_store(sel_q[i], addr_q[i], val_q[i], 1'b1);
					"N":     drive_store(sel_q[i], addr_q[i], val_q[i], 1'b0);
					"L":     fetch_load(sel_q[i], addr_q[i], val_q[i], 1'b1);
					default: fetch_load(sel_q[i], addr_q[i], val_q[i], 1'b0);
				endcase
			end
			@(posedge clk);
			if (op_q.size() == 0) begin
				$display("cases file held no accesses");
				$display("TB FAILED");
				$fatal(1, "nothing was exercised");
			end else begin
				$display("TB PASSED");
				$finish;
			end
		end
	end

endmodule

// File: verification/dmem_bridge_cases.txt
# op sel addr value, all hex; op S store, N store with dm_wr low
# op L load checked against value, op U load not checked
# first load after reset reads unwritten memory
U 2 a0000100 00000000
# word store and word load, base removed
S 2 a0000040 12345678
L 2 a0000040 12345678
S 2 a0000ffc cafef00d
L 2 a0000ffc cafef00d
S 7 a0000800 0badbeef
L 0 a0000800 0badbeef
S 2 a0000044 89abcdef
L 2 a0000040 12345678
L 7 a0000044 89abcdef
# byte stores build one word lane by lane
S 2 a0000080 ffffffff
S 0 a0000080 aabbcc11
L 2 a0000080 ffffff11
S 0 a0000081 00000022
L 2 a0000080 ffff2211
S 0 a0000082 12345633
L 2 a0000080 ff332211
S 0 a0000083 00000044
L 2 a0000080 44332211
# halfword stores replace one half
S 2 a00000c0 01234567
S 1 a00000c0 ffffbeef
L 2 a00000c0 0123beef
S 1 a00000c2 0000dead
L 2 a00000c0 deadbeef
L 5 a00000c2 0000dead
L 3 a00000c3 000000de
# sign and zero extension
S 2 a0000140 80ff7f85
L 4 a0000140 ffffff85
L 3 a0000140 00000085
L 4 a0000141 0000007f
L 3 a0000141 0000007f
L 4 a0000142 ffffffff
L 3 a0000142 000000ff
L 4 a0000143 ffffff80
L 3 a0000143 00000080
L 6 a0000140 00007f85
L 5 a0000140 00007f85
L 6 a0000142 ffff80ff
L 5 a0000142 000080ff
S 2 a0000144 0001c3a5
L 6 a0000144 ffffc3a5
L 5 a0000144 0000c3a5
L 6 a0000146 00000001
# stores with dm_wr low change nothing
N 2 a0000040 ffffffff
L 2 a0000040 12345678
N 0 a0000081 000000aa
L 2 a0000080 44332211
N 1 a00000c2 00001234
L 2 a00000c0 deadbeef

// File: build.f
hw/dmem_pkg.sv
hw/sram_port_if.sv
hw/store_lane_format.sv
hw/load_lane_extract.sv
hw/data_sram_bank.sv
hw/dmem_bridge.sv
verification/tb_dmem_bridge.sv

// File: Bender.yml
package:
  name: dmem_bridge

sources:
  # synthesizable data-memory bridge
  - target: rtl
    files:
      - hw/dmem_pkg.sv
      - hw/sram_port_if.sv
      - hw/store_lane_format.sv
      - hw/load_lane_extract.sv
      - hw/data_sram_bank.sv
      - hw/dmem_bridge.sv

  # self-checking testbench, top tb_dmem_bridge
  - target: test
    files:
      - verification/tb_dmem_bridge.sv

# top level of the design is dmem_bridge
